// ==== sim.f ====
src/front_end_pkg.sv
src/register_file.sv
src/fetch_unit.sv
src/instr_buffer.sv
src/decode_issue.sv
src/front_end.sv
test/front_end_test.sv

// ==== Makefile ====
TOP := front_end_test

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// ==== test/front_end_test.sv ====
`timescale 1ns/1ps
`default_nettype none

module front_end_test import front_end_pkg::*; ();

    localparam addr_t RESET_PC  = 32'h0000_0100;
    localparam int    BUF_DEPTH = 4;
    localparam int    CREDITS   = 2;
    localparam int    NUM_UOPS  = 400;
    localparam int    MEM_WORDS = 1024;

    logic        clk;
    logic        arst_n;
    icache_rsp_t icache_rsp;
    logic        exception;
    logic        interrupt;
    addr_t       handler_pc;
    logic        executed;
    logic        branch;
    logic        jump;
    logic        outcome;
    addr_t       branch_target;
    writeback_t  writeback;
    logic        credit;
    icache_req_t icache_req;
    logic        uop_valid;
    exu_uop_t    uop;

    logic [31:0] lfsr_q;
    data_word_t  prog_mem [MEM_WORDS];
    data_word_t  shadow [32];   // Register values as the back end sees them.
    addr_t       exp_pc;        // PC of the next expected uop.
    addr_t       exp_fetch;     // Address of the next new cache request.
    logic        redirect_drv;
    addr_t       redirect_tgt;
    int          uops_checked;
    int          uop_errors;
    int          addr_errors;
    int          flag_errors;
    int          credit_errors;

    front_end #(
        .RESET_PC  (RESET_PC),
        .BUF_DEPTH (BUF_DEPTH),
        .CREDITS   (CREDITS)
    ) DUT (
        .clk_i           (clk),
        .arst_n_i        (arst_n),
        .icache_rsp_i    (icache_rsp),
        .exception_i     (exception),
        .interrupt_i     (interrupt),
        .handler_pc_i    (handler_pc),
        .executed_i      (executed),
        .branch_i        (branch),
        .jump_i          (jump),
        .outcome_i       (outcome),
        .branch_target_i (branch_target),
        .writeback_i     (writeback),
        .credit_i        (credit),
        .icache_req_o    (icache_req),
        .uop_valid_o     (uop_valid),
        .uop_o           (uop)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // **************************************************
    // Random words and reference decode
    // **************************************************

    // Taps x^32 + x^22 + x^2 + x + 1 with one step per bit.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            r      = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic data_word_t make_instr();
        logic [3:0]  cls;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm12;
        logic [6:0]  f7;
        data_word_t  w;
        cls   = 4'(rand_bits(4));
        rd    = 5'(rand_bits(5));
        rs1   = 5'(rand_bits(5));
        rs2   = 5'(rand_bits(5));
        f3    = 3'(rand_bits(3));
        imm12 = 12'(rand_bits(12));
        f7    = 7'h00;
        case (cls)
            4'd0, 4'd1: begin
                if ((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1) == 32'd1) begin
                    f7 = 7'h20;  // SUB or SRA.
                end
                w = {f7, rs2, rs1, f3, rd, 7'b0110011};
            end
            4'd2, 4'd3: begin
                if (f3 == 3'd1) begin
                    imm12[11:5] = 7'h00;
                end
                if (f3 == 3'd5) begin
                    imm12[11:5] = (rand_bits(1) == 32'd1) ? 7'h20 : 7'h00;
                end
                w = {imm12, rs1, f3, rd, 7'b0010011};
            end
            4'd4: begin
                if (f3 inside {3'd3, 3'd6, 3'd7}) begin
                    f3 = 3'd0;
                end
                w = {imm12, rs1, f3, rd, 7'b0000011};
            end
            4'd5: begin
                f3 = (f3[1:0] == 2'd3) ? 3'd2 : {1'b0, f3[1:0]};
                w  = {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b0100011};
            end
            4'd6, 4'd7: begin
                if (f3 inside {3'd2, 3'd3}) begin
                    f3[1] = 1'b0;
                end
                w = {imm12[11:5], rs2, rs1, f3, imm12[4:0], 7'b1100011};
            end
            4'd8:    w = {imm12, rs1, f3, rd, 7'b1101111};
            4'd9:    w = {imm12, rs1, 3'b000, rd, 7'b1100111};
            4'd10:   w = {imm12, rs1, f3, rd, 7'b0110111};
            4'd11:   w = {imm12, rs1, f3, rd, 7'b0010111};
            4'd12, 4'd13: w = rand_bits(32);  // Mostly illegal.
            default: w = {imm12, rs1, f3, rd, 7'b1110011};  // SYSTEM.
        endcase
        return w;
    endfunction

    function automatic data_word_t sext(input logic [31:0] v, input int bits);
        return data_word_t'($signed(v << (32 - bits)) >>> (32 - bits));
    endfunction

    function automatic data_word_t mem_word(input addr_t addr);
        return prog_mem[addr[11:2]];
    endfunction

    function automatic exu_uop_t ref_decode(input data_word_t w, input addr_t pc);
        exu_uop_t   u;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       rs1_used;
        logic       rs2_used;
        logic       rd_used;
        f3       = w[14:12];
        f7       = w[31:25];
        u        = '0;
        u.unit   = ILLEGAL;
        rs1_used = 1'b0;
        rs2_used = 1'b0;
        rd_used  = 1'b0;
        case (w[6:0])
            7'b0110011: if (f7 == 7'h00 || (f7 == 7'h20 && f3 inside {3'd0, 3'd5})) begin
                u.unit                         = ALU;
                {rs1_used, rs2_used, rd_used}  = 3'b111;
            end
            7'b0010011: if (!(f3 == 3'd1 && f7 != 7'h00) &&
                            !(f3 == 3'd5 && !(f7 inside {7'h00, 7'h20}))) begin
                u.unit              = ALU_IMM;
                u.imm               = sext(32'(w[31:20]), 12);
                {rs1_used, rd_used} = 2'b11;
            end
            7'b0000011: if (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) begin
                u.unit              = LOAD;
                u.imm               = sext(32'(w[31:20]), 12);
                {rs1_used, rd_used} = 2'b11;
            end
            7'b0100011: if (f3 inside {3'd0, 3'd1, 3'd2}) begin
                u.unit               = STORE;
                u.imm                = sext(32'({w[31:25], w[11:7]}), 12);
                {rs1_used, rs2_used} = 2'b11;
            end
            7'b1100011: if (!(f3 inside {3'd2, 3'd3})) begin
                u.unit               = BRANCH;
                u.imm                = sext(32'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
                {rs1_used, rs2_used} = 2'b11;
            end
            7'b1101111: begin
                u.unit  = JAL;
                u.imm   = sext(32'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
                rd_used = 1'b1;
            end
            7'b1100111: if (f3 == 3'd0) begin
                u.unit              = JALR;
                u.imm               = sext(32'(w[31:20]), 12);
                {rs1_used, rd_used} = 2'b11;
            end
            7'b0110111, 7'b0010111: begin
                u.unit  = (w[5] == 1'b1) ? LUI : AUIPC;
                u.imm   = {w[31:12], 12'h000};
                rd_used = 1'b1;
            end
            default: u.unit = ILLEGAL;
        endcase
        u.funct3     = f3;
        u.funct7_5   = w[30];
        u.rd         = rd_used ? w[11:7] : 5'd0;
        u.pc         = pc;
        u.operand[0] = rs1_used ? shadow[w[19:15]] : 32'd0;
        u.operand[1] = rs2_used ? shadow[w[24:20]] : 32'd0;
        return u;
    endfunction

    // **************************************************
    // Compare tasks
    // **************************************************

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            addr_errors++;
            $display("Error at %t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_uop(input string name, input exu_uop_t got, input exu_uop_t exp);
        exu_unit_t got_unit;
        exu_unit_t exp_unit;
        got_unit = got.unit;
        exp_unit = exp.unit;
        if (got !== exp) begin
            uop_errors++;
            $display("Error at %t: %s = %h (%s), expected %h (%s)", $time, name,
                     got, got_unit.name(), exp, exp_unit.name());
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("Error at %t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    // **************************************************
    // Cache and back end models
    // **************************************************

    initial begin : drive_models
        logic       pending;
        logic       stale;    // Open request was overtaken by a redirect.
        logic       hit;
        int         wait_cnt;
        int         hold_cnt;
        int         in_flight;
        int         cycle_no;
        addr_t      pend_addr;
        logic [5:0] kind;
        pending   = 1'b0;
        stale     = 1'b0;
        hit       = 1'b0;
        wait_cnt  = 0;
        hold_cnt  = 0;
        in_flight = 0;
        cycle_no  = 0;
        pend_addr = '0;
        wait (arst_n === 1'b1);
        forever begin
            @(posedge clk);
            if (writeback.valid && writeback.rd != 5'd0) begin
                shadow[writeback.rd] = writeback.value;
            end
            if (redirect_drv) begin
                exp_pc = redirect_tgt;  // Uops after this edge start at the target.
            end
            #1;
            cycle_no++;

            if (hit) begin
                pending = 1'b0;
            end
            hit = 1'b0;
            if (icache_req.valid) begin
                if (!pending) begin
                    check_addr("icache_req_o.addr", icache_req.addr, exp_fetch);
                    pending   = 1'b1;
                    stale     = 1'b0;
                    pend_addr = icache_req.addr;
                    wait_cnt  = 1 + int'(rand_bits(2) % 3);
                end else begin
                    check_addr("icache_req_o.addr", icache_req.addr, pend_addr);
                    wait_cnt--;
                    hit = (wait_cnt == 0);
                end
            end else if (pending) begin
                check_flag("icache_req_o.valid", icache_req.valid, 1'b1);
                pending = 1'b0;
            end
            icache_rsp.hit  = hit;
            icache_rsp.word = hit ? mem_word(pend_addr) : 32'd0;

            {executed, branch, jump, outcome, exception, interrupt} = 6'b0;
            branch_target = {20'h0, 10'(rand_bits(10)), 2'b00};
            handler_pc    = {20'h0, 10'(rand_bits(10)), 2'b00};
            kind          = (cycle_no > 20) ? 6'(rand_bits(6)) : 6'd63;
            case (kind)
                6'd0: {executed, branch, outcome} = 3'b111;
                6'd1: {executed, jump} = 2'b11;
                6'd2: {executed, branch} = 2'b11;       // Not taken.
                6'd3: {branch, outcome, jump} = 3'b111;  // Never executed.
                6'd4: exception = 1'b1;
                6'd5: interrupt = 1'b1;
                6'd6: {exception, executed, branch, outcome} = 4'b1111;
                default: executed = 1'b0;
            endcase
            redirect_drv = kind inside {6'd0, 6'd1, 6'd4, 6'd5, 6'd6};
            redirect_tgt = (kind inside {6'd4, 6'd5, 6'd6}) ? handler_pc : branch_target;

            if (redirect_drv) begin
                if (pending && !hit) begin
                    stale = 1'b1;
                end
                exp_fetch = redirect_tgt;
            end else if (hit && !stale) begin
                exp_fetch = pend_addr + 32'd4;
            end

            writeback.valid = 1'(rand_bits(1));
            writeback.rd    = 5'(rand_bits(5));
            writeback.value = rand_bits(32);

            if (uop_valid) begin
                in_flight++;
                if (in_flight > CREDITS) begin
                    credit_errors++;
                    $display("Credit overflow at %t: %0d uops held by the back end, %0d slots",
                             $time, in_flight, CREDITS);
                end
            end
            credit = 1'b0;
            if (hold_cnt > 0) begin
                hold_cnt--;  // Long stall lets the buffer fill.
            end else if (rand_bits(5) == 32'd0) begin
                hold_cnt = 10 + int'(rand_bits(5));
            end else if (in_flight > 0 && rand_bits(1) == 32'd1) begin
                credit = 1'b1;
                in_flight--;
            end
        end
    end

    initial begin : compare_uops
        exu_uop_t expected;
        wait (arst_n === 1'b1);
        forever begin
            @(negedge clk);
            if (uop_valid) begin
                expected = ref_decode(mem_word(exp_pc), exp_pc);
                check_addr("uop_o.pc", uop.pc, exp_pc);
                check_uop("uop_o", uop, expected);
                exp_pc = exp_pc + 32'd4;
                uops_checked++;
            end
        end
    end

    initial begin : watchdog
        repeat (NUM_UOPS * 40) @(posedge clk);
        $display("Timeout: only %0d of %0d uops arrived", uops_checked, NUM_UOPS);
        $display("Test FAILED");
        $finish;
    end

    // **************************************************
    // Reset and end of run
    // **************************************************

    initial begin
        $timeformat(-9, 0, " ns", 0);
        arst_n        = 1'b0;
        icache_rsp    = '0;
        exception     = 1'b0;
        interrupt     = 1'b0;
        handler_pc    = '0;
        executed      = 1'b0;
        branch        = 1'b0;
        jump          = 1'b0;
        outcome       = 1'b0;
        branch_target = '0;
        writeback     = '0;
        credit        = 1'b0;
        lfsr_q        = 32'hc73;
        exp_pc        = RESET_PC;
        exp_fetch     = RESET_PC;
        redirect_drv  = 1'b0;
        redirect_tgt  = '0;
        uops_checked  = 0;
        uop_errors    = 0;
        addr_errors   = 0;
        flag_errors   = 0;
        credit_errors = 0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            prog_mem[a] = make_instr();
        end
        for (int r = 0; r < 32; r++) begin
            shadow[r] = '0;
        end

        repeat (2) @(posedge clk);
        #1;
        check_flag("icache_req_o.valid", icache_req.valid, 1'b0);
        check_flag("uop_valid_o", uop_valid, 1'b0);
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        #1;
        check_flag("icache_req_o.valid", icache_req.valid, 1'b0);
        check_flag("uop_valid_o", uop_valid, 1'b0);
        @(posedge clk);
        #1;
        check_flag("icache_req_o.valid", icache_req.valid, 1'b1);  // First request.

        wait (uops_checked >= NUM_UOPS);
        @(posedge clk);
        $display("Checked %0d uops; errors: uop %0d, address %0d, flag %0d, credit %0d",
                 uops_checked, uop_errors, addr_errors, flag_errors, credit_errors);
        if (uop_errors + addr_errors + flag_errors + credit_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : front_end_test

`default_nettype wire

// ==== src/front_end.sv ====
`timescale 1ns/1ps
`default_nettype none

module front_end import front_end_pkg::*; #(
    parameter addr_t RESET_PC  = 32'h0000_0000,
    parameter int    BUF_DEPTH = 4,
    parameter int    CREDITS   = 2
) (
    input  wire                clk_i,
    input  wire                arst_n_i,
    input  wire  icache_rsp_t  icache_rsp_i,
    input  wire                exception_i,
    input  wire                interrupt_i,
    input  wire  addr_t        handler_pc_i,
    input  wire                executed_i,
    input  wire                branch_i,
    input  wire                jump_i,
    input  wire                outcome_i,
    input  wire  addr_t        branch_target_i,
    input  wire  writeback_t   writeback_i,
    input  wire                credit_i,
    output icache_req_t        icache_req_o,
    output logic               uop_valid_o,
    output exu_uop_t           uop_o
);

    logic         trap;
    logic         branch_taken;
    redirect_t    redirect;
    logic         push;
    logic         pop;
    logic         space;
    logic         not_empty;
    fetch_entry_t fetch_entry;
    fetch_entry_t head;
    reg_idx_t     raddr1, raddr2;
    data_word_t   rdata1, rdata2;

    // **************************************************
    // Redirect with trap priority
    // **************************************************

    assign trap            = exception_i || interrupt_i;
    assign branch_taken    = executed_i && ((branch_i && outcome_i) || jump_i);
    assign redirect.valid  = trap || branch_taken;
    assign redirect.target = trap ? handler_pc_i : branch_target_i;

    fetch_unit #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .icache_rsp_i (icache_rsp_i),
        .redirect_i   (redirect),
        .space_i      (space),
        .icache_req_o (icache_req_o),
        .push_o       (push),
        .entry_o      (fetch_entry)
    );

    instr_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_buffer (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .flush_i     (redirect.valid),
        .push_i      (push),
        .entry_i     (fetch_entry),
        .pop_i       (pop),
        .head_o      (head),
        .not_empty_o (not_empty),
        .space_o     (space)
    );

    decode_issue #(
        .CREDITS (CREDITS)
    ) u_decode (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .flush_i     (redirect.valid),
        .head_i      (head),
        .not_empty_i (not_empty),
        .credit_i    (credit_i),
        .rdata1_i    (rdata1),
        .rdata2_i    (rdata2),
        .pop_o       (pop),
        .raddr1_o    (raddr1),
        .raddr2_o    (raddr2),
        .uop_valid_o (uop_valid_o),
        .uop_o       (uop_o)
    );

    register_file u_regfile (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .writeback_i (writeback_i),
        .raddr1_i    (raddr1),
        .raddr2_i    (raddr2),
        .rdata1_o    (rdata1),
        .rdata2_o    (rdata2)
    );

endmodule : front_end

`default_nettype wire

// ==== src/decode_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_issue import front_end_pkg::*; #(
    parameter int CREDITS = 2
) (
    input  wire                 clk_i,
    input  wire                 arst_n_i,
    input  wire                 flush_i,
    input  wire  fetch_entry_t  head_i,
    input  wire                 not_empty_i,
    input  wire                 credit_i,
    input  wire  data_word_t    rdata1_i,
    input  wire  data_word_t    rdata2_i,
    output logic                pop_o,
    output reg_idx_t            raddr1_o,
    output reg_idx_t            raddr2_o,
    output logic                uop_valid_o,
    output exu_uop_t            uop_o
);

    localparam int CRD_W = $clog2(CREDITS + 1);

    data_word_t       instr;
    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic             op_ok, op_imm_ok;
    exu_unit_t        unit;
    data_word_t       imm;
    logic             use_rs1, use_rs2, writes_rd;
    exu_uop_t         uop_d;
    logic [CRD_W-1:0] credit_cnt_q;

    assign instr  = head_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // SUB and SRA are the only funct7 variants of OP.
    assign op_ok = (funct7 == 7'b0000000) ||
                   ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));

    assign op_imm_ok = (funct3 == 3'b001) ? (funct7 == 7'b0000000) :
                       (funct3 == 3'b101) ? (funct7 == 7'b0000000 || funct7 == 7'b0100000) :
                       1'b1;

    // **************************************************
    // Opcode decode and immediate
    // **************************************************

    always_comb begin
        unit      = ILLEGAL;
        imm       = '0;
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        writes_rd = 1'b0;

        case (opcode)
            OPC_OP: if (op_ok) begin
                unit      = ALU;
                use_rs1   = 1'b1;
                use_rs2   = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_OP_IMM: if (op_imm_ok) begin
                unit      = ALU_IMM;
                imm       = {{20{instr[31]}}, instr[31:20]};
                use_rs1   = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_LOAD: if (funct3 != 3'b011 && funct3[2:1] != 2'b11) begin
                unit      = LOAD;
                imm       = {{20{instr[31]}}, instr[31:20]};
                use_rs1   = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_STORE: if (funct3[2] == 1'b0 && funct3 != 3'b011) begin
                unit    = STORE;
                imm     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OPC_BRANCH: if (funct3[2:1] != 2'b01) begin
                unit    = BRANCH;
                imm     = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OPC_JAL: begin
                unit      = JAL;
                imm       = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                             instr[30:21], 1'b0};
                writes_rd = 1'b1;
            end
            OPC_JALR: if (funct3 == 3'b000) begin
                unit      = JALR;
                imm       = {{20{instr[31]}}, instr[31:20]};
                use_rs1   = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_LUI, OPC_AUIPC: begin
                unit      = (opcode == OPC_LUI) ? LUI : AUIPC;
                imm       = {instr[31:12], 12'b0};
                writes_rd = 1'b1;
            end
            default: unit = ILLEGAL;  // FENCE and SYSTEM land here too.
        endcase
    end

    // Unused source fields read x0 and give a zero operand.
    assign raddr1_o = use_rs1 ? instr[19:15] : '0;
    assign raddr2_o = use_rs2 ? instr[24:20] : '0;

    always_comb begin
        uop_d.unit       = unit;
        uop_d.funct3     = funct3;
        uop_d.funct7_5   = instr[30];
        uop_d.rd         = writes_rd ? instr[11:7] : '0;
        uop_d.imm        = imm;
        uop_d.pc         = head_i.pc;
        uop_d.operand[0] = rdata1_i;
        uop_d.operand[1] = rdata2_i;
    end

    // **************************************************
    // Issue and credits
    // **************************************************

    assign pop_o = not_empty_i && (credit_cnt_q != '0) && !flush_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            credit_cnt_q <= CRD_W'(CREDITS);
        end else if (pop_o && !credit_i) begin
            credit_cnt_q <= credit_cnt_q - 1'b1;
        end else if (credit_i && !pop_o) begin
            credit_cnt_q <= credit_cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            uop_valid_o <= 1'b0;
        end else begin
            uop_valid_o <= pop_o;  // Low on a flush edge.
        end
    end

    always_ff @(posedge clk_i) begin
        if (pop_o) begin
            uop_o <= uop_d;
        end
    end

endmodule : decode_issue

`default_nettype wire

// ==== src/instr_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_buffer import front_end_pkg::*; #(
    parameter int BUF_DEPTH = 4
) (
    input  wire                 clk_i,
    input  wire                 arst_n_i,
    input  wire                 flush_i,
    input  wire                 push_i,
    input  wire  fetch_entry_t  entry_i,
    input  wire                 pop_i,
    output fetch_entry_t        head_o,
    output logic                not_empty_o,
    output logic                space_o
);

    localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
    localparam int CNT_W = $clog2(BUF_DEPTH + 1);

    fetch_entry_t     mem_q [BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             do_push, do_pop;

    // Pointer wraps at BUF_DEPTH.
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(BUF_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_push = push_i && !flush_i && (count_q != CNT_W'(BUF_DEPTH));
    assign do_pop  = pop_i && !flush_i && (count_q != '0);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;  // Redirect empties the buffer.
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

    assign head_o      = mem_q[rd_ptr_q];
    assign not_empty_o = (count_q != '0);
    assign space_o     = (count_q < CNT_W'(BUF_DEPTH - 1));  // One slot kept for the word in flight.

endmodule : instr_buffer

`default_nettype wire

// ==== src/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit import front_end_pkg::*; #(
    parameter addr_t RESET_PC = 32'h0000_0000
) (
    input  wire                clk_i,
    input  wire                arst_n_i,
    input  wire  icache_rsp_t  icache_rsp_i,
    input  wire  redirect_t    redirect_i,
    input  wire                space_i,
    output icache_req_t        icache_req_o,
    output logic               push_o,
    output fetch_entry_t       entry_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_HIT,
        DISCARD
    } fetch_state_t;

    fetch_state_t state_q, state_d;
    addr_t        pc_q, pc_d;              // Next address to fetch.
    addr_t        req_addr_q, req_addr_d;  // Address of the open request.
    addr_t        pc_next;

    assign pc_next = pc_q + 32'd4;

    // **************************************************
    // Request sequencing
    // **************************************************

    always_comb begin
        state_d    = state_q;
        pc_d       = pc_q;
        req_addr_d = req_addr_q;

        case (state_q)
            IDLE: begin
                if (redirect_i.valid) begin
                    pc_d = redirect_i.target;
                end else if (space_i) begin
                    req_addr_d = pc_q;
                    state_d    = WAIT_HIT;
                end
            end

            WAIT_HIT: begin
                if (redirect_i.valid) begin
                    pc_d    = redirect_i.target;
                    state_d = icache_rsp_i.hit ? IDLE : DISCARD;  // Open request goes stale.
                end else if (icache_rsp_i.hit) begin
                    pc_d = pc_next;
                    if (space_i) begin
                        req_addr_d = pc_next;  // Back to back request.
                    end else begin
                        state_d = IDLE;
                    end
                end
            end

            DISCARD: begin
                if (redirect_i.valid) begin
                    pc_d = redirect_i.target;
                end
                // Stale word is dropped here.
                if (icache_rsp_i.hit) begin
                    if (space_i && !redirect_i.valid) begin
                        req_addr_d = pc_q;
                        state_d    = WAIT_HIT;
                    end else begin
                        state_d = IDLE;
                    end
                end
            end

            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= IDLE;
            pc_q       <= RESET_PC;
            req_addr_q <= RESET_PC;
        end else begin
            state_q    <= state_d;
            pc_q       <= pc_d;
            req_addr_q <= req_addr_d;
        end
    end

    // **************************************************
    // Outputs
    // **************************************************

    assign icache_req_o.valid = (state_q != IDLE);  // Held until the hit.
    assign icache_req_o.addr  = req_addr_q;

    assign push_o         = (state_q == WAIT_HIT) && icache_rsp_i.hit;
    assign entry_o.pc     = req_addr_q;
    assign entry_o.instr  = icache_rsp_i.word;

endmodule : fetch_unit

`default_nettype wire

// ==== src/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file import front_end_pkg::*; (
    input  wire               clk_i,
    input  wire               arst_n_i,
    input  wire  writeback_t  writeback_i,
    input  wire  reg_idx_t    raddr1_i,
    input  wire  reg_idx_t    raddr2_i,
    output data_word_t        rdata1_o,
    output data_word_t        rdata2_o
);

    data_word_t regs_q [1:31];  // x0 has no storage.

    // Zero for x0, then bypass, then the array.
    function automatic data_word_t read_port(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (writeback_i.valid && writeback_i.rd == idx) begin
            return writeback_i.value;
        end
        return regs_q[idx];
    endfunction

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (writeback_i.valid && writeback_i.rd != '0) begin
            regs_q[writeback_i.rd] <= writeback_i.value;
        end
    end

    always_comb begin
        rdata1_o = read_port(raddr1_i);
    end

    always_comb begin
        rdata2_o = read_port(raddr2_i);
    end

endmodule : register_file

`default_nettype wire

// ==== src/front_end_pkg.sv ====
`default_nettype none

package front_end_pkg;

    // **************************************************
    // Widths
    // **************************************************

    typedef logic [31:0] data_word_t;  // Data or instruction word.
    typedef logic [31:0] addr_t;       // Byte address.
    typedef logic [4:0]  reg_idx_t;    // Register index.

    // RV32I major opcodes.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    typedef enum logic [3:0] {
        ALU,
        ALU_IMM,
        LOAD,
        STORE,
        BRANCH,
        JAL,
        JALR,
        LUI,
        AUIPC,
        ILLEGAL
    } exu_unit_t;

    // **************************************************
    // Link payloads
    // **************************************************

    typedef struct packed {
        logic  valid;
        addr_t addr;
    } icache_req_t;

    typedef struct packed {
        logic       hit;
        data_word_t word;
    } icache_rsp_t;

    typedef struct packed {
        addr_t      pc;
        data_word_t instr;
    } fetch_entry_t;

    typedef struct packed {
        logic  valid;
        addr_t target;
    } redirect_t;

    typedef struct packed {
        logic       valid;
        reg_idx_t   rd;
        data_word_t value;
    } writeback_t;

    typedef struct packed {
        exu_unit_t        unit;
        logic [2:0]       funct3;
        logic             funct7_5;
        reg_idx_t         rd;
        data_word_t       imm;       // Sign extended.
        addr_t            pc;
        data_word_t [1:0] operand;   // [0] is rs1, [1] is rs2.
    } exu_uop_t;

endpackage : front_end_pkg

`default_nettype wire
